// ==== Bender.yml ====
package:
  name: alu_stage

sources:
  # Package first, then the execute blocks, then the pipeline stages
  - common/alu_pkg.sv
  - alu/alu_cla.sv
  - alu/alu_shifter.sv
  - alu/alu_core.sv
  - logic/alu_decode.sv
  - logic/alu_result.sv
  - logic/alu_stage.sv
  - target: test
    files:
      - verif/alu_checker.sv
      - verif/alu_stage_tb.sv

// ==== alu/alu_cla.sv ====
// Carry-lookahead adder of four 4-bit groups with a second lookahead level
// Shared by add, subtract, compares and carry-out in the execute core
`timescale 1ns/100ps

module alu_cla
	import alu_pkg::*;
(
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	input  logic              carry_i,
	output logic [DATA_W-1:0] sum_o,
	output logic              carry_o
);

	logic [DATA_W-1:0] g;       // Bit generate
	logic [DATA_W-1:0] p;       // Bit propagate
	logic [N_GRP-1:0]  grp_g;   // Group generate
	logic [N_GRP-1:0]  grp_p;   // Group propagate
	logic [N_GRP:0]    grp_c;   // Carry into each group
	logic [DATA_W-1:0] c;       // Carry into each bit

	assign g = a_i & b_i;
	assign p = a_i ^ b_i;

	for (genvar j = 0; j < N_GRP; j++) begin : g_grp
		localparam int B0 = j * GRP_W; // Lowest bit of group

		assign grp_g[j] = g[B0+3] | (p[B0+3] & g[B0+2]) |
			(p[B0+3] & p[B0+2] & g[B0+1]) |
			(p[B0+3] & p[B0+2] & p[B0+1] & g[B0]);
		assign grp_p[j] = &p[B0 +: GRP_W];

		// Bit carries inside the group from its lookahead carry
		assign c[B0]   = grp_c[j];
		assign c[B0+1] = g[B0] | (p[B0] & grp_c[j]);
		assign c[B0+2] = g[B0+1] | (p[B0+1] & g[B0]) | (p[B0+1] & p[B0] & grp_c[j]);
		assign c[B0+3] = g[B0+2] | (p[B0+2] & g[B0+1]) | (p[B0+2] & p[B0+1] & g[B0]) |
			(p[B0+2] & p[B0+1] & p[B0] & grp_c[j]);
	end

	// Second level, all group carries straight from carry_i
	assign grp_c[0] = carry_i;
	assign grp_c[1] = grp_g[0] | (grp_p[0] & carry_i);
	assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & carry_i);
	assign grp_c[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0]) |
		(grp_p[2] & grp_p[1] & grp_p[0] & carry_i);
	assign grp_c[4] = grp_g[3] | (grp_p[3] & grp_g[2]) | (grp_p[3] & grp_p[2] & grp_g[1]) |
		(grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0]) |
		(grp_p[3] & grp_p[2] & grp_p[1] & grp_p[0] & carry_i);

	assign sum_o   = p ^ c;
	assign carry_o = grp_c[N_GRP];

	// Lookahead network against a plain 17-bit add
	always_comb begin
		a_sum_matches: assert #0 ({carry_o, sum_o} == ({1'b0, a_i} + {1'b0, b_i} + carry_i))
			else $error("cla sum mismatch");
	end

endmodule

// ==== alu/alu_core.sv ====
// Combinational execute core with the sixteen ALU operations
// Drives one shared adder and the barrel shifter, returns result and LT
`timescale 1ns/100ps

module alu_core
	import alu_pkg::*;
(
	input  alu_op_e           op_i,
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	input  logic [DATA_W-1:0] pc2_i,
	input  logic              pass_sel_i, // Pass-through picks B
	output logic [DATA_W-1:0] result_o,
	output logic              lt_o
);

	localparam int MSB = DATA_W - 1;

	logic [DATA_W-1:0] add_a;     // Adder operand A
	logic [DATA_W-1:0] add_b;     // Adder operand B
	logic              add_cin;
	logic [DATA_W-1:0] add_sum;
	logic              add_cout;
	logic [DATA_W-1:0] shift_out;
	shift_mode_e       shift_mode;
	logic [DATA_W-1:0] rev;       // A bit reversed
	logic [DATA_W-1:0] pass_val;  // Pass-through operand
	logic              is_eq;
	logic              signed_lt;

	// Operand steering for the single adder
	always_comb begin
		add_a   = a_i;  // Add and carry-out
		add_b   = b_i;
		add_cin = 1'b0;
		case (op_i)
			OP_SUB: begin
				add_a   = b_i;  // B + ~A + 1
				add_b   = ~a_i;
				add_cin = 1'b1;
			end
			OP_SLT, OP_SLE: begin
				add_b   = ~b_i; // A + ~B + 1
				add_cin = 1'b1;
			end
			default: begin
				add_cin = 1'b0;
			end
		endcase
	end

	alu_cla u_cla (
		.a_i     (add_a),
		.b_i     (add_b),
		.carry_i (add_cin),
		.sum_o   (add_sum),
		.carry_o (add_cout)
	);

	assign shift_mode = shift_mode_e'(op_i[1:0]); // Low op bits pick the shift kind

	alu_shifter u_shifter (
		.data_i  (a_i),
		.shamt_i (b_i[SHAMT_W-1:0]),
		.mode_i  (shift_mode),
		.data_o  (shift_out)
	);

	always_comb begin
		for (int i = 0; i < DATA_W; i++) begin
			rev[i] = a_i[MSB-i];
		end
	end

	assign is_eq    = (a_i == b_i);
	assign pass_val = pass_sel_i ? b_i : a_i;

	// Same signs means the difference cannot overflow, else A negative wins
	assign signed_lt = (a_i[MSB] == b_i[MSB]) ? add_sum[MSB] : a_i[MSB];

	always_comb begin
		result_o = '0;
		lt_o     = 1'b0; // Defined zero outside compares and pass
		case (op_i)
			OP_ADD, OP_SUB:  result_o = add_sum;
			OP_XOR:          result_o = a_i ^ b_i;
			OP_ANDN:         result_o = a_i & ~b_i;
			OP_ROL, OP_SLL,
			OP_ROR, OP_SRL:  result_o = shift_out;
			OP_SEQ:          result_o = DATA_W'(is_eq);
			OP_SLT: begin
				result_o = DATA_W'(signed_lt);
				lt_o     = signed_lt;
			end
			OP_SLE: begin
				result_o = DATA_W'(signed_lt | is_eq);
				lt_o     = signed_lt; // Strict less-than even here
			end
			OP_SCO:          result_o = DATA_W'(add_cout);
			OP_BTR:          result_o = rev;
			OP_PASS: begin
				result_o = pass_val;
				lt_o     = pass_val[MSB]; // Sign of the passed operand
			end
			OP_SLBI:         result_o = {a_i[7:0], b_i[7:0]};
			OP_PC2:          result_o = pc2_i;
			default:         result_o = '0;
		endcase
	end

endmodule

// ==== alu/alu_shifter.sv ====
// Barrel shifter for the two rotates and two logical shifts
// Four levels move the word by 1, 2, 4 and 8 under control of the shift amount
`timescale 1ns/100ps

module alu_shifter
	import alu_pkg::*;
(
	input  logic [DATA_W-1:0]  data_i,
	input  logic [SHAMT_W-1:0] shamt_i,
	input  shift_mode_e        mode_i,
	output logic [DATA_W-1:0]  data_o
);

	logic              is_left; // Direction
	logic              is_rot;  // Wrap bits around instead of zero fill
	logic [DATA_W-1:0] level [SHAMT_W+1];

	assign is_left = (mode_i == SHIFT_ROL) || (mode_i == SHIFT_SLL);
	assign is_rot  = (mode_i == SHIFT_ROL) || (mode_i == SHIFT_ROR);

	assign level[0] = data_i;

	for (genvar k = 0; k < SHAMT_W; k++) begin : g_level
		localparam int DIST = 1 << k; // Distance of this level

		logic [DIST-1:0] wrap_l; // Enters at the bottom on a left move
		logic [DIST-1:0] wrap_r; // Enters at the top on a right move

		assign wrap_l = is_rot ? level[k][DATA_W-1 -: DIST] : '0;
		assign wrap_r = is_rot ? level[k][DIST-1:0] : '0;

		assign level[k+1] = !shamt_i[k] ? level[k] :
			is_left ? {level[k][DATA_W-DIST-1:0], wrap_l} :
			{wrap_r, level[k][DATA_W-1:DIST]};
	end

	assign data_o = level[SHAMT_W];

endmodule

// ==== common/alu_pkg.sv ====
// Shared widths, instruction field positions and operation codes of the execute subsystem
// Imported by the decode, execute and result stages and by the testbench
package alu_pkg;

	localparam int DATA_W  = 16; // Datapath width
	localparam int OP_W    = 4;  // Operation code width
	localparam int SHAMT_W = 4;  // Shift amount from low bits of B
	localparam int REG_W   = 3;  // Destination register field
	localparam int IMM_W   = 7;  // Immediate field

	// Instruction word layout
	localparam int OP_LSB       = 12; // Op code in 15:12
	localparam int IMM_SEL_BIT  = 11; // Use immediate as operand B
	localparam int PASS_SEL_BIT = 10; // Pass-through picks B when set
	localparam int RD_LSB       = 7;  // Destination in 9:7

	// Carry lookahead grouping
	localparam int GRP_W = 4;              // Bits per group
	localparam int N_GRP = DATA_W / GRP_W; // Groups per word

	typedef enum logic [OP_W-1:0] {
		OP_ADD  = 4'b0000, // A + B
		OP_SUB  = 4'b0001, // B - A
		OP_XOR  = 4'b0010,
		OP_ANDN = 4'b0011, // A & ~B
		OP_ROL  = 4'b0100,
		OP_SLL  = 4'b0101,
		OP_ROR  = 4'b0110,
		OP_SRL  = 4'b0111,
		OP_SEQ  = 4'b1000, // A == B
		OP_SLT  = 4'b1001, // Signed A < B
		OP_SLE  = 4'b1010, // Signed A <= B
		OP_SCO  = 4'b1011, // Carry out of A + B
		OP_BTR  = 4'b1100, // Bit reverse of A
		OP_PASS = 4'b1101, // A or B by select bit
		OP_SLBI = 4'b1110, // Low byte of A above low byte of B
		OP_PC2  = 4'b1111  // PC + 2
	} alu_op_e;

	// Low two bits of a shift op code
	typedef enum logic [1:0] {
		SHIFT_ROL = 2'b00,
		SHIFT_SLL = 2'b01,
		SHIFT_ROR = 2'b10,
		SHIFT_SRL = 2'b11
	} shift_mode_e;

endpackage

// ==== logic/alu_decode.sv ====
// Decode stage of the execute pipeline, one cycle of latency
// Registers the instruction fields and picks the immediate or rt as operand B
`timescale 1ns/100ps

module alu_decode
	import alu_pkg::*;
(
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              valid_i,    // Instruction present this cycle
	input  logic [DATA_W-1:0] instr_i,
	input  logic [DATA_W-1:0] rs_data_i,  // Operand A
	input  logic [DATA_W-1:0] rt_data_i,  // Operand B unless immediate
	input  logic [DATA_W-1:0] pc2_i,
	output logic              valid_o,
	output logic              pass_sel_o,
	output alu_op_e           op_o,
	output logic [DATA_W-1:0] a_o,
	output logic [DATA_W-1:0] b_o,
	output logic [DATA_W-1:0] pc2_o,
	output logic [REG_W-1:0]  rd_o
);

	logic              imm_sel;   // Bit 11 of the instruction
	logic [DATA_W-1:0] imm_ext;   // Zero-extended immediate
	logic [DATA_W-1:0] b_sel;     // Operand B after mux

	assign imm_sel = instr_i[IMM_SEL_BIT];
	assign imm_ext = {{(DATA_W-IMM_W){1'b0}}, instr_i[IMM_W-1:0]};
	assign b_sel   = imm_sel ? imm_ext : rt_data_i;

	// Stage valid
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// Fields only load on a live instruction, idle cycles hold them
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			op_o       <= alu_op_e'(instr_i[OP_LSB +: OP_W]);
			pass_sel_o <= instr_i[PASS_SEL_BIT];
			rd_o       <= instr_i[RD_LSB +: REG_W];
			a_o        <= rs_data_i;
			b_o        <= b_sel;
			pc2_o      <= pc2_i;
		end
	end

	// No instruction leaves decode right after a reset cycle
	a_valid_after_reset: assert property (
		@(posedge clk_i) reset_i |=> !valid_o
	) else $error("decode valid high after reset");

endmodule

// ==== logic/alu_result.sv ====
// Result stage of the execute pipeline, one cycle of latency
// Registers the value with the zero flag, LT and destination register
`timescale 1ns/100ps

module alu_result
	import alu_pkg::*;
(
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              valid_i,
	input  logic              lt_i,
	input  logic [DATA_W-1:0] result_i,
	input  logic [REG_W-1:0]  rd_i,
	output logic              valid_o,
	output logic              eq_o,     // Result is zero
	output logic              lt_o,
	output logic [DATA_W-1:0] result_o,
	output logic [REG_W-1:0]  rd_o
);

	logic eq_d; // Zero detect ahead of the register

	assign eq_d = (result_i == '0);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// Outputs hold their last values across idle cycles
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			result_o <= result_i;
			eq_o     <= eq_d;
			lt_o     <= lt_i;
			rd_o     <= rd_i;
		end
	end

	// Flag and value leave together
	a_eq_tracks_result: assert property (
		@(posedge clk_i) disable iff (reset_i)
		valid_o |-> (eq_o == (result_o == '0))
	) else $error("eq_o disagrees with result_o");

endmodule

// ==== logic/alu_stage.sv ====
// Top of the integer execute subsystem, decode then execute then result
// Takes one instruction per cycle and returns it two edges later
`timescale 1ns/100ps

module alu_stage
	import alu_pkg::*;
(
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              valid_i,
	input  logic [DATA_W-1:0] instr_i,
	input  logic [DATA_W-1:0] rs_data_i,
	input  logic [DATA_W-1:0] rt_data_i,
	input  logic [DATA_W-1:0] pc2_i,
	output logic              valid_o,
	output logic              eq_o,
	output logic              lt_o,
	output logic [DATA_W-1:0] result_o,
	output logic [REG_W-1:0]  rd_o
);

	logic              dec_valid;  // Decode to result
	logic              dec_pass_sel;
	alu_op_e           dec_op;
	logic [DATA_W-1:0] dec_a;
	logic [DATA_W-1:0] dec_b;
	logic [DATA_W-1:0] dec_pc2;
	logic [REG_W-1:0]  dec_rd;
	logic [DATA_W-1:0] ex_result;  // Core to result
	logic              ex_lt;

	alu_decode u_decode (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.valid_i    (valid_i),
		.instr_i    (instr_i),
		.rs_data_i  (rs_data_i),
		.rt_data_i  (rt_data_i),
		.pc2_i      (pc2_i),
		.valid_o    (dec_valid),
		.pass_sel_o (dec_pass_sel),
		.op_o       (dec_op),
		.a_o        (dec_a),
		.b_o        (dec_b),
		.pc2_o      (dec_pc2),
		.rd_o       (dec_rd)
	);

	alu_core u_core (
		.op_i       (dec_op),
		.a_i        (dec_a),
		.b_i        (dec_b),
		.pc2_i      (dec_pc2),
		.pass_sel_i (dec_pass_sel),
		.result_o   (ex_result),
		.lt_o       (ex_lt)
	);

	alu_result u_result (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.valid_i  (dec_valid),
		.lt_i     (ex_lt),
		.result_i (ex_result),
		.rd_i     (dec_rd),
		.valid_o  (valid_o),
		.eq_o     (eq_o),
		.lt_o     (lt_o),
		.result_o (result_o),
		.rd_o     (rd_o)
	);

endmodule

// ==== project.f ====
common/alu_pkg.sv
alu/alu_cla.sv
alu/alu_shifter.sv
alu/alu_core.sv
logic/alu_decode.sv
logic/alu_result.sv
logic/alu_stage.sv
verif/alu_checker.sv
verif/alu_stage_tb.sv

// ==== verif/alu_checker.sv ====
// Scoreboard for the execute pipeline, models every operation from the instruction rules
// Watches the DUT ports, queues expected values per accepted instruction and compares at valid_o
`timescale 1ns/100ps

module alu_checker
	import alu_pkg::*;
(
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              in_valid_i,
	input  logic [DATA_W-1:0] in_instr_i,
	input  logic [DATA_W-1:0] in_a_i,
	input  logic [DATA_W-1:0] in_b_i,     // rt before the immediate mux
	input  logic [DATA_W-1:0] in_pc2_i,
	input  logic [95:0]       in_name_i,  // Twelve characters
	input  logic              in_chk_i,   // Table carries a result
	input  logic [DATA_W-1:0] in_exp_i,
	input  logic              out_valid_i,
	input  logic [DATA_W-1:0] out_result_i,
	input  logic              out_eq_i,
	input  logic              out_lt_i,
	input  logic [REG_W-1:0]  out_rd_i,
	output int                test_cnt_o,
	output int                err_cnt_o,
	output int                pending_o   // Instructions still in flight
);

	logic [95:0]       q_name [$];
	logic [DATA_W-1:0] q_res [$];
	logic              q_lt [$];
	logic [REG_W-1:0]  q_rd [$];
	logic              q_chk [$];
	logic [DATA_W-1:0] q_exp [$];
	logic [1:0]        valid_hist;  // valid_i of the last two edges
	logic              test_bad;

	// Returns {lt, result}
	function automatic logic [DATA_W:0] model_op(input logic [DATA_W-1:0] instr,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] rt, input logic [DATA_W-1:0] pc2);
		logic [DATA_W-1:0]   b;
		logic [DATA_W-1:0]   res;
		logic                lt;
		logic [2*DATA_W-1:0] dbl;   // A twice, rotates are windows into it
		logic [DATA_W:0]     wide;
		int                  sh;
		b    = instr[IMM_SEL_BIT] ? DATA_W'(instr[IMM_W-1:0]) : rt;
		sh   = b[SHAMT_W-1:0];
		dbl  = {a, a};
		wide = {1'b0, a} + {1'b0, b};
		lt   = 1'b0;
		res  = '0;
		case (alu_op_e'(instr[OP_LSB +: 4]))
			OP_ADD:  res = a + b;
			OP_SUB:  res = b - a;
			OP_XOR:  res = a ^ b;
			OP_ANDN: res = a & ~b;
			OP_ROL:  res = dbl[2*DATA_W-1-sh -: DATA_W];
			OP_SLL:  res = a << sh;
			OP_ROR:  res = dbl[sh +: DATA_W];
			OP_SRL:  res = a >> sh;
			OP_SEQ:  res = (a == b) ? 16'd1 : 16'd0;
			OP_SLT: begin
				lt  = $signed(a) < $signed(b);
				res = DATA_W'(lt);
			end
			OP_SLE: begin
				lt  = $signed(a) < $signed(b);   // Strict, equal gives low
				res = ($signed(a) <= $signed(b)) ? 16'd1 : 16'd0;
			end
			OP_SCO:  res = DATA_W'(wide[DATA_W]);
			OP_BTR: begin
				for (int i = 0; i < DATA_W; i++) begin
					res[i] = a[DATA_W-1-i];
				end
			end
			OP_PASS: begin
				res = instr[PASS_SEL_BIT] ? b : a;
				lt  = res[DATA_W-1];   // Sign of what passed
			end
			OP_SLBI: res = {a[7:0], b[7:0]};
			OP_PC2:  res = pc2;
			default: res = '0;
		endcase
		return {lt, res};
	endfunction

	// Drops the zero padding in front of a short name
	function automatic string to_name(input logic [95:0] v);
		string s;
		s = "";
		for (int i = 11; i >= 0; i--) begin
			if (v[8*i +: 8] != 8'h00) begin
				s = $sformatf("%s%c", s, v[8*i +: 8]);
			end
		end
		return s;
	endfunction

	task automatic compare_field(input string tname, input string field,
		input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s %s: expected 0x%h, actual 0x%h", tname, field, exp, act);
			test_bad = 1'b1;
		end
	endtask

	always @(posedge clk_i) begin : watch
		logic [DATA_W:0] m;
		string           tname;
		if (reset_i) begin
			valid_hist = 2'b00;
			q_name.delete();
			q_res.delete();
			q_lt.delete();
			q_rd.delete();
			q_chk.delete();
			q_exp.delete();
			test_cnt_o = 0;
			err_cnt_o  = 0;
		end else begin
			// Output valid must mirror input valid two edges back
			if (out_valid_i !== valid_hist[1]) begin
				$display("valid_o is %b but the input two cycles earlier had valid %b",
					out_valid_i, valid_hist[1]);
				err_cnt_o++;
			end
			valid_hist = {valid_hist[0], in_valid_i};
			if (out_valid_i === 1'b1 && q_res.size() == 0) begin
				$display("valid_o is high with no instruction in flight");
				err_cnt_o++;
			end else if (out_valid_i === 1'b1) begin
				tname    = to_name(q_name.pop_front());
				test_bad = 1'b0;
				m        = {q_lt.pop_front(), q_res.pop_front()};
				compare_field(tname, "result", m[DATA_W-1:0], out_result_i);
				if (q_chk.pop_front()) begin
					compare_field(tname, "table result", q_exp.pop_front(), out_result_i);
				end else begin
					void'(q_exp.pop_front());
				end
				compare_field(tname, "eq", DATA_W'(m[DATA_W-1:0] == '0), DATA_W'(out_eq_i));
				compare_field(tname, "lt", DATA_W'(m[DATA_W]), DATA_W'(out_lt_i));
				compare_field(tname, "rd", DATA_W'(q_rd.pop_front()), DATA_W'(out_rd_i));
				test_cnt_o++;
				if (test_bad) begin
					err_cnt_o++;
				end
				$display("%s test %0d %s", test_bad ? "FAIL" : "ok  ", test_cnt_o, tname);
			end
			if (in_valid_i === 1'b1) begin
				m = model_op(in_instr_i, in_a_i, in_b_i, in_pc2_i);
				q_name.push_back(in_name_i);
				q_res.push_back(m[DATA_W-1:0]);
				q_lt.push_back(m[DATA_W]);
				q_rd.push_back(in_instr_i[RD_LSB +: REG_W]);
				q_chk.push_back(in_chk_i);
				q_exp.push_back(in_exp_i);
			end
		end
		pending_o = q_res.size();
	end

endmodule

// ==== verif/alu_stage_tb.sv ====
// Testbench top for the execute pipeline, a directed table followed by a random stream
// Drives the DUT on the rising edge, the checker module does all comparing
`timescale 1ns/100ps

module alu_stage_tb;
	import alu_pkg::*;

	localparam int NAME_W       = 96;  // Twelve characters
	localparam int TBL_N        = 40;
	localparam int N_RAND       = 64;
	localparam int DRAIN_CYCLES = 10;

	logic              clk_i;
	logic              reset_i;
	logic              valid_i;
	logic [DATA_W-1:0] instr_i;
	logic [DATA_W-1:0] rs_data_i;
	logic [DATA_W-1:0] rt_data_i;
	logic [DATA_W-1:0] pc2_i;
	logic [NAME_W-1:0] name;       // Travels with the instruction to the checker
	logic              chk;
	logic [DATA_W-1:0] exp_val;
	logic              valid_o;
	logic              eq_o;
	logic              lt_o;
	logic [DATA_W-1:0] result_o;
	logic [REG_W-1:0]  rd_o;
	int                test_cnt;
	int                err_cnt;
	int                pending;

	// Stimulus table, expected result only where chk is set
	logic [NAME_W-1:0] tbl_name  [TBL_N];
	logic [DATA_W-1:0] tbl_instr [TBL_N];
	logic [DATA_W-1:0] tbl_a     [TBL_N];
	logic [DATA_W-1:0] tbl_b     [TBL_N];
	logic [DATA_W-1:0] tbl_pc2   [TBL_N];
	logic              tbl_chk   [TBL_N];
	logic [DATA_W-1:0] tbl_exp   [TBL_N];
	int                n_entries;
	logic [NAME_W-1:0] shift_names [4];
	int                shamts [4];
	logic [31:0]       rand_state;
	logic [31:0]       rand_a;     // Next two LCG steps give the operands
	logic [31:0]       rand_b;
	logic              timed_out;
	int                wait_cycles;

	alu_stage dut_i (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.valid_i   (valid_i),
		.instr_i   (instr_i),
		.rs_data_i (rs_data_i),
		.rt_data_i (rt_data_i),
		.pc2_i     (pc2_i),
		.valid_o   (valid_o),
		.eq_o      (eq_o),
		.lt_o      (lt_o),
		.result_o  (result_o),
		.rd_o      (rd_o)
	);

	alu_checker u_checker (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.in_valid_i   (valid_i),
		.in_instr_i   (instr_i),
		.in_a_i       (rs_data_i),
		.in_b_i       (rt_data_i),
		.in_pc2_i     (pc2_i),
		.in_name_i    (name),
		.in_chk_i     (chk),
		.in_exp_i     (exp_val),
		.out_valid_i  (valid_o),
		.out_result_i (result_o),
		.out_eq_i     (eq_o),
		.out_lt_i     (lt_o),
		.out_rd_i     (rd_o),
		.test_cnt_o   (test_cnt),
		.err_cnt_o    (err_cnt),
		.pending_o    (pending)
	);

	always #50 clk_i = ~clk_i; // 100 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [DATA_W-1:0] make_instr(input alu_op_e op, input logic imm_sel,
		input logic pass_sel, input logic [REG_W-1:0] rd, input logic [IMM_W-1:0] imm);
		return {op, imm_sel, pass_sel, rd, imm};
	endfunction

	task automatic add_entry(input logic [NAME_W-1:0] nm, input logic [DATA_W-1:0] ins,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] pc2,
		input logic c, input logic [DATA_W-1:0] e);
		tbl_name[n_entries]  = nm;
		tbl_instr[n_entries] = ins;
		tbl_a[n_entries]     = a;
		tbl_b[n_entries]     = b;
		tbl_pc2[n_entries]   = pc2;
		tbl_chk[n_entries]   = c;
		tbl_exp[n_entries]   = e;
		n_entries++;
	endtask

	task automatic drive_instr(input logic [NAME_W-1:0] nm, input logic [DATA_W-1:0] ins,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] pc2,
		input logic c, input logic [DATA_W-1:0] e);
		@(posedge clk_i);
		valid_i   <= 1'b1;
		instr_i   <= ins;
		rs_data_i <= a;
		rt_data_i <= b;
		pc2_i     <= pc2;
		name      <= nm;
		chk       <= c;
		exp_val   <= e;
	endtask

	task automatic build_table();
		add_entry("add_ovf", make_instr(OP_ADD, 0, 0, 1, 0), 16'h7fff, 16'h0001, 0, 1, 16'h8000);
		add_entry("sub_b_a", make_instr(OP_SUB, 0, 0, 2, 0), 16'h0005, 16'h0003, 0, 1, 16'hfffe);
		add_entry("sco_carry", make_instr(OP_SCO, 0, 0, 3, 0), 16'hffff, 16'h0001, 0, 1, 16'h0001);
		add_entry("add_wrap", make_instr(OP_ADD, 0, 0, 4, 0), 16'hffff, 16'h0001, 0, 1, 16'h0000);
		add_entry("xor", make_instr(OP_XOR, 0, 0, 5, 0), 16'hf0f0, 16'hff00, 0, 1, 16'h0ff0);
		add_entry("andn", make_instr(OP_ANDN, 0, 0, 6, 0), 16'hf0f0, 16'hff00, 0, 1, 16'h00f0);
		add_entry("btr", make_instr(OP_BTR, 0, 0, 7, 0), 16'h0001, 16'h0000, 0, 1, 16'h8000);
		add_entry("slbi", make_instr(OP_SLBI, 0, 0, 0, 0), 16'h12ab, 16'h00cd, 0, 1, 16'habcd);
		add_entry("slt_mixed", make_instr(OP_SLT, 0, 0, 1, 0), 16'h8000, 16'h0001, 0, 1, 16'h0001);
		add_entry("sle_equal", make_instr(OP_SLE, 0, 0, 2, 0), 16'h1234, 16'h1234, 0, 1, 16'h0001);
		add_entry("seq", make_instr(OP_SEQ, 0, 0, 3, 0), 16'h5555, 16'h5555, 0, 1, 16'h0001);
		add_entry("seq_diff", make_instr(OP_SEQ, 0, 0, 4, 0), 16'h5555, 16'h5554, 0, 1, 16'h0000);
		add_entry("pass_b", make_instr(OP_PASS, 0, 1, 5, 0), 16'h0001, 16'h9000, 0, 1, 16'h9000);
		add_entry("pass_a", make_instr(OP_PASS, 0, 0, 6, 0), 16'h0001, 16'h9000, 0, 1, 16'h0001);
		add_entry("add_imm", make_instr(OP_ADD, 1, 0, 7, 7'h7f), 16'h0100, 16'hdead, 0, 1,
			16'h017f);
		add_entry("slbi_imm", make_instr(OP_SLBI, 1, 0, 0, 7'h55), 16'h12ab, 16'hffff, 0, 1,
			16'hab55);
		add_entry("pc2", make_instr(OP_PC2, 0, 0, 5, 0), 16'h1111, 16'h2222, 16'h1236, 1, 16'h1236);
		// Every mode at each amount, upper bits of B must not matter
		for (int m = 0; m < 4; m++) begin
			for (int k = 0; k < 4; k++) begin
				add_entry(shift_names[m], make_instr(alu_op_e'(4'(4 + m)), 0, 0, 3'(k), 0),
					16'hb3c5, {12'ha5a, 4'(shamts[k])}, 0, k == 0, 16'hb3c5);
			end
		end
	endtask

	initial begin
		clk_i      = 1'b0;
		reset_i    = 1'b1;
		valid_i    = 1'b0;
		instr_i    = '0;
		rs_data_i  = '0;
		rt_data_i  = '0;
		pc2_i      = '0;
		name       = '0;
		chk        = 1'b0;
		exp_val    = '0;
		n_entries  = 0;
		timed_out  = 1'b0;
		rand_state = 32'h3fda8285;
		rand_a     = '0;
		rand_b     = '0;
		shift_names[0] = "rol";
		shift_names[1] = "sll";
		shift_names[2] = "ror";
		shift_names[3] = "srl";
		shamts[0] = 0;
		shamts[1] = 1;
		shamts[2] = 8;
		shamts[3] = 15;
		build_table();
		repeat (3) @(posedge clk_i);
		reset_i <= 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			drive_instr(tbl_name[i], tbl_instr[i], tbl_a[i], tbl_b[i], tbl_pc2[i], tbl_chk[i],
				tbl_exp[i]);
		end
		// Back to back, one bubble halfway
		for (int i = 0; i < N_RAND; i++) begin
			if (i == N_RAND / 2) begin
				@(posedge clk_i);
				valid_i <= 1'b0;
			end
			rand_state = lcg_next(rand_state);
			rand_a     = lcg_next(rand_state);
			rand_b     = lcg_next(rand_a);
			drive_instr("random", rand_state[31:16], rand_a[31:16], rand_b[31:16],
				rand_state[15:0] & 16'hfffe, 0, 0);
			rand_state = rand_b;
		end
		@(posedge clk_i);
		valid_i <= 1'b0;
		wait_cycles = 0;
		@(negedge clk_i);
		while (pending != 0 && wait_cycles < DRAIN_CYCLES) begin
			@(negedge clk_i);
			wait_cycles++;
		end
		if (pending != 0) begin
			$display("Timed out: %0d instructions never reached valid_o", pending);
			timed_out = 1'b1;
		end
		repeat (2) @(negedge clk_i); // Let the checker see valid_o fall
		$display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out && test_cnt == n_entries + N_RAND) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
